// File: rtl/pkt_buffer_pkg.sv
package pkt_buffer_pkg;

	//////////////////////////////////////////////////////////////////////
	// Default sizes

	// Word width of the data path, header included
	localparam int DATA_WIDTH_DEFAULT = 32;

	// FIFO depth in words, must be a power of two
	localparam int FIFO_DEPTH_DEFAULT = 64;

	// Flops in each clock-crossing chain
	localparam int SYNC_STAGES = 2;

	//////////////////////////////////////////////////////////////////////
	// Ingress packet outcome

	typedef enum logic [1:0] {
		PKT_OK          = 2'd0,	// Committed
		PKT_BAD_LENGTH  = 2'd1,	// Payload count differs from header, rolled back
		PKT_NO_SPACE    = 2'd2,	// Not enough room, nothing written
		PKT_ZERO_LENGTH = 2'd3	// Header said zero, rolled back
	} pkt_status_t;

endpackage

// File: rtl/dual_port_ram.sv
`timescale 1ns/1ps

module dual_port_ram #(
	parameter int DATA_WIDTH = 32,
	parameter int DEPTH      = 64
) (
	// Write port
	input  logic                         wr_clk,
	input  logic                         wr_en,
	input  logic [$clog2(DEPTH)-1:0]     wr_addr,
	input  logic [DATA_WIDTH-1:0]        wr_data,

	// Read port, output registered
	input  logic                         rd_clk,
	input  logic                         rd_en,
	input  logic [$clog2(DEPTH)-1:0]     rd_addr,
	output logic [DATA_WIDTH-1:0]        rd_data
);

	// Storage array
	logic [DATA_WIDTH-1:0] mem [DEPTH];

	//////////////////////////////////////////////////////////////////////
	// Write side

	always_ff @(posedge wr_clk) begin
		if (wr_en)
			mem[wr_addr] <= wr_data;	// One word per cycle
	end

	//////////////////////////////////////////////////////////////////////
	// Read side

	// Word shows on rd_data one rd_clk cycle after rd_en
	always_ff @(posedge rd_clk) begin
		if (rd_en)
			rd_data <= mem[rd_addr];	// Holds until the next read
	end

endmodule

// File: rtl/pointer_sync.sv
`timescale 1ns/1ps

module pointer_sync #(
	parameter int WIDTH = 7
) (
	// Sending side
	input  logic             src_clk,
	input  logic             src_reset,
	input  logic             src_update,	// Value changed, send it
	input  logic [WIDTH-1:0] src_value,

	// Receiving side
	input  logic             dst_clk,
	input  logic             dst_reset,
	output logic [WIDTH-1:0] dst_value
);

	localparam int STAGES = pkt_buffer_pkg::SYNC_STAGES;

	//////////////////////////////////////////////////////////////////////
	// Source domain

	logic             req;			// Four-phase request level
	logic             ack;			// Four-phase acknowledge level, dst_clk
	logic             pending;		// Update seen while busy
	logic [WIDTH-1:0] held;			// Captured value, stable while req or ack high
	logic [STAGES-1:0] ack_sync;	// Ack into src_clk
	logic             ack_s;
	logic             start;

	assign ack_s = ack_sync[STAGES-1];

	// Idle only once the previous ack has fallen too
	assign start = !req && !ack_s && (src_update || pending);

	always_ff @(posedge src_clk) begin
		if (src_reset) begin
			req      <= 1'b0;
			pending  <= 1'b0;
			ack_sync <= '0;
		end else begin
			ack_sync <= {ack_sync[STAGES-2:0], ack};
			pending  <= (pending || src_update) && !start;	// Latest value goes next
			if (start)
				req <= 1'b1;
			else if (req && ack_s)
				req <= 1'b0;	// Value taken, release
		end
	end

	// Captured at transfer start, so a held update sends the newest pointer
	always_ff @(posedge src_clk) begin
		if (start)
			held <= src_value;
	end

	//////////////////////////////////////////////////////////////////////
	// Destination domain

	logic [STAGES-1:0] req_sync;	// Req into dst_clk
	logic              req_s;

	assign req_s = req_sync[STAGES-1];

	always_ff @(posedge dst_clk) begin
		if (dst_reset) begin
			ack       <= 1'b0;
			req_sync  <= '0;
			dst_value <= '0;
		end else begin
			req_sync <= {req_sync[STAGES-2:0], req};
			if (req_s && !ack) begin
				dst_value <= held;	// Settled for SYNC_STAGES cycles by now
				ack       <= 1'b1;
			end else if (!req_s) begin
				ack <= 1'b0;	// Last phase
			end
		end
	end

endmodule

// File: rtl/packet_fifo_core.sv
`timescale 1ns/1ps

module packet_fifo_core #(
	parameter int DATA_WIDTH = 32,
	parameter int DEPTH      = 64
) (
	// Write side, wr_clk domain
	input  logic                        wr_clk,
	output logic                        wr_reset,	// rd_reset carried into wr_clk
	input  logic                        wr_en,
	input  logic [DATA_WIDTH-1:0]       wr_data,
	input  logic                        wr_commit,	// Publish all words written so far
	input  logic                        wr_rollback,	// Drop words since last commit
	output logic [$clog2(DEPTH):0]      wr_size,	// Free words

	// Read side, rd_clk domain
	input  logic                        rd_clk,
	input  logic                        rd_reset,
	input  logic                        rd_en,
	input  logic [$clog2(DEPTH)-1:0]    rd_offset,	// From packet start
	output logic [DATA_WIDTH-1:0]       rd_data,
	input  logic                        rd_pop_packet,
	input  logic [$clog2(DEPTH):0]      rd_packet_size,
	output logic [$clog2(DEPTH):0]      rd_size	// Committed words not yet popped
);

	localparam int ADDR_BITS = $clog2(DEPTH);
	localparam int STAGES    = pkt_buffer_pkg::SYNC_STAGES;
	localparam logic [ADDR_BITS:0] DEPTH_WORDS = (ADDR_BITS + 1)'(DEPTH);

	//////////////////////////////////////////////////////////////////////
	// Reset into the write domain

	logic [STAGES-1:0] reset_pipe;

	always_ff @(posedge wr_clk) begin
		reset_pipe <= {reset_pipe[STAGES-2:0], rd_reset};
	end

	assign wr_reset = reset_pipe[STAGES-1];

	//////////////////////////////////////////////////////////////////////
	// Write pointers

	logic [ADDR_BITS:0] wr_ptr;		// Extra bit tells full from empty
	logic [ADDR_BITS:0] commit_ptr;	// Last published position
	logic [ADDR_BITS:0] head_ptr;	// Read pointer as seen from wr_clk
	logic               tail_update;

	always_ff @(posedge wr_clk) begin
		if (wr_reset) begin
			wr_ptr      <= '0;
			commit_ptr  <= '0;
			tail_update <= 1'b0;
		end else begin
			tail_update <= wr_commit;	// commit_ptr has settled one cycle on
			if (wr_rollback)
				wr_ptr <= commit_ptr;	// Overrides a write in the same cycle
			else if (wr_en)
				wr_ptr <= wr_ptr + 1'b1;
			if (wr_commit)
				commit_ptr <= wr_ptr;
		end
	end

	assign wr_size = DEPTH_WORDS + head_ptr - wr_ptr;	// Uncommitted words count as used

	//////////////////////////////////////////////////////////////////////
	// Read pointer

	logic [ADDR_BITS:0]   rd_ptr;
	logic [ADDR_BITS:0]   tail_ptr;		// Committed pointer as seen from rd_clk
	logic [ADDR_BITS-1:0] rd_addr;
	logic                 head_update;

	always_ff @(posedge rd_clk) begin
		if (rd_reset) begin
			rd_ptr      <= '0;
			head_update <= 1'b0;
		end else begin
			head_update <= rd_pop_packet;
			if (rd_pop_packet)
				rd_ptr <= rd_ptr + rd_packet_size;	// Whole packet at once
		end
	end

	assign rd_addr = rd_ptr[ADDR_BITS-1:0] + rd_offset;	// Wraps in the array
	assign rd_size = tail_ptr - rd_ptr;

	//////////////////////////////////////////////////////////////////////
	// Storage and pointer crossings

	dual_port_ram #(
		.DATA_WIDTH (DATA_WIDTH),
		.DEPTH      (DEPTH)
	) u_ram (
		.wr_clk  (wr_clk),
		.wr_en   (wr_en),
		.wr_addr (wr_ptr[ADDR_BITS-1:0]),
		.wr_data (wr_data),
		.rd_clk  (rd_clk),
		.rd_en   (rd_en),
		.rd_addr (rd_addr),
		.rd_data (rd_data)
	);

	// Tail to the read side
	pointer_sync #(.WIDTH(ADDR_BITS + 1)) u_tail_sync (
		.src_clk    (wr_clk),
		.src_reset  (wr_reset),
		.src_update (tail_update),
		.src_value  (commit_ptr),
		.dst_clk    (rd_clk),
		.dst_reset  (rd_reset),
		.dst_value  (tail_ptr)
	);

	// Head to the write side
	pointer_sync #(.WIDTH(ADDR_BITS + 1)) u_head_sync (
		.src_clk    (rd_clk),
		.src_reset  (rd_reset),
		.src_update (head_update),
		.src_value  (rd_ptr),
		.dst_clk    (wr_clk),
		.dst_reset  (wr_reset),
		.dst_value  (head_ptr)
	);

endmodule

// File: rtl/packet_ingress.sv
`timescale 1ns/1ps

module packet_ingress #(
	parameter int DATA_WIDTH = 32,
	parameter int DEPTH      = 64
) (
	input  logic                          wr_clk,
	input  logic                          wr_reset,

	// Four-phase source port
	input  logic                          in_req,
	output logic                          in_ack,
	input  logic [DATA_WIDTH-1:0]         in_data,
	input  logic                          in_last,
	output pkt_buffer_pkg::pkt_status_t   in_status,	// Held until next last word

	// FIFO write side
	output logic                          wr_en,
	output logic [DATA_WIDTH-1:0]         wr_data,
	output logic                          wr_commit,
	output logic                          wr_rollback,
	input  logic [$clog2(DEPTH):0]        wr_size
);

	logic                  req_q;			// in_req registered
	logic                  in_packet;		// Header taken, payload expected
	logic                  discard;			// No room, swallow the rest
	logic                  commit_pend;
	logic                  rollback_pend;
	logic [DATA_WIDTH-1:0] pay_len;			// Length from header
	logic [DATA_WIDTH-1:0] pay_cnt;			// Payload words seen
	logic                  accept;
	logic                  hdr_fits;
	logic [DATA_WIDTH-1:0] cur_len;
	logic [DATA_WIDTH-1:0] cnt_next;
	pkt_buffer_pkg::pkt_status_t end_status;

	//////////////////////////////////////////////////////////////////////
	// Word decode

	assign accept   = req_q && !in_ack;	// New word, data held stable by source
	assign hdr_fits = in_data < DATA_WIDTH'(wr_size);	// Length plus one fits
	assign cur_len  = in_packet ? pay_len : in_data;	// Lone header uses its own field
	assign cnt_next = in_packet ? pay_cnt + 1'b1 : '0;

	// Outcome if this word ends the packet
	always_comb begin
		if (in_packet ? discard : !hdr_fits)
			end_status = pkt_buffer_pkg::PKT_NO_SPACE;
		else if (cur_len == '0)
			end_status = pkt_buffer_pkg::PKT_ZERO_LENGTH;
		else if (cnt_next != cur_len)
			end_status = pkt_buffer_pkg::PKT_BAD_LENGTH;	// Short, long or header only
		else
			end_status = pkt_buffer_pkg::PKT_OK;
	end

	//////////////////////////////////////////////////////////////////////
	// Handshake and control

	always_ff @(posedge wr_clk) begin
		if (wr_reset) begin
			req_q         <= 1'b0;
			in_ack        <= 1'b0;
			in_packet     <= 1'b0;
			discard       <= 1'b0;
			wr_en         <= 1'b0;
			wr_commit     <= 1'b0;
			wr_rollback   <= 1'b0;
			commit_pend   <= 1'b0;
			rollback_pend <= 1'b0;
			in_status     <= pkt_buffer_pkg::PKT_OK;
		end else begin
			req_q         <= in_req;
			wr_en         <= 1'b0;
			wr_commit     <= commit_pend;	// One cycle after the last write
			wr_rollback   <= rollback_pend;
			commit_pend   <= 1'b0;
			rollback_pend <= 1'b0;
			if (accept) begin
				in_ack <= 1'b1;
				if (!in_packet) begin
					wr_en     <= hdr_fits;	// Header goes in only with room
					discard   <= !hdr_fits;
					in_packet <= !in_last;
				end else begin
					wr_en <= !discard && (pay_cnt < pay_len);	// Never past header length
					if (in_last)
						in_packet <= 1'b0;
				end
				if (in_last) begin
					in_status     <= end_status;
					commit_pend   <= (end_status == pkt_buffer_pkg::PKT_OK);
					rollback_pend <= (end_status == pkt_buffer_pkg::PKT_BAD_LENGTH) ||
						(end_status == pkt_buffer_pkg::PKT_ZERO_LENGTH);
				end
			end else if (!req_q) begin
				in_ack <= 1'b0;	// Source has let go
			end
		end
	end

	// Payload registers
	always_ff @(posedge wr_clk) begin
		if (accept) begin
			wr_data <= in_data;
			pay_cnt <= cnt_next;
			if (!in_packet)
				pay_len <= in_data;
		end
	end

endmodule

// File: rtl/packet_egress.sv
`timescale 1ns/1ps

module packet_egress #(
	parameter int DATA_WIDTH = 32,
	parameter int DEPTH      = 64
) (
	input  logic                          rd_clk,
	input  logic                          rd_reset,

	// FIFO read side
	output logic                          rd_en,
	output logic [$clog2(DEPTH)-1:0]      rd_offset,
	input  logic [DATA_WIDTH-1:0]         rd_data,	// One cycle after rd_en
	input  logic [$clog2(DEPTH):0]        rd_size,
	output logic                          rd_pop_packet,
	output logic [$clog2(DEPTH):0]        rd_packet_size,

	// Four-phase sink port
	output logic                          out_req,
	input  logic                          out_ack,
	output logic [DATA_WIDTH-1:0]         out_data,
	output logic                          out_last
);

	localparam int ADDR_BITS = $clog2(DEPTH);

	typedef enum logic [3:0] {
		S_IDLE,		// Wait for a committed header
		S_HDR_RD,	// Read offset 0
		S_HDR,		// Header on rd_data
		S_WAIT,		// Wait for the whole packet
		S_DATA_RD,	// Read payload word
		S_DATA,		// Payload word on rd_data
		S_ACK,		// out_req high
		S_REL,		// Wait for out_ack to fall
		S_POP
	} state_t;

	state_t               state;
	logic [ADDR_BITS:0]   pkt_words;	// Header plus payload
	logic [ADDR_BITS-1:0] idx;			// Payload offset
	logic                 idx_last;

	assign rd_en          = (state == S_HDR_RD) || (state == S_DATA_RD);
	assign rd_offset      = (state == S_DATA_RD) ? idx : '0;
	assign rd_pop_packet  = (state == S_POP);
	assign rd_packet_size = pkt_words;
	assign idx_last       = ({1'b0, idx} == pkt_words - 1'b1);

	//////////////////////////////////////////////////////////////////////
	// Packet FSM

	always_ff @(posedge rd_clk) begin
		if (rd_reset) begin
			state    <= S_IDLE;
			out_req  <= 1'b0;
			out_last <= 1'b0;
		end else begin
			case (state)
				S_IDLE:    if (rd_size != '0) state <= S_HDR_RD;
				S_HDR_RD:  state <= S_HDR;
				S_HDR:     state <= S_WAIT;
				S_WAIT:    if (rd_size >= pkt_words) state <= S_DATA_RD;	// All committed
				S_DATA_RD: state <= S_DATA;
				S_DATA: begin
					out_req  <= 1'b1;
					out_last <= idx_last;	// Only on the final word
					state    <= S_ACK;
				end
				S_ACK: begin
					if (out_ack) begin
						out_req <= 1'b0;	// Sink has the word
						state   <= S_REL;
					end
				end
				S_REL: begin
					if (!out_ack)
						state <= out_last ? S_POP : S_DATA_RD;
				end
				S_POP:     state <= S_IDLE;	// rd_size drops on this edge
				default:   state <= S_IDLE;
			endcase
		end
	end

	// Length, offset and word registers
	always_ff @(posedge rd_clk) begin
		if (state == S_HDR) begin
			pkt_words <= rd_data[ADDR_BITS:0] + 1'b1;	// Committed length fits DEPTH
			idx       <= ADDR_BITS'(1);
		end else if (state == S_REL && !out_ack) begin
			idx <= idx + 1'b1;
		end
		if (state == S_DATA)
			out_data <= rd_data;
	end

endmodule

// File: rtl/packet_buffer_top.sv
`timescale 1ns/1ps

module packet_buffer_top #(
	parameter int DATA_WIDTH = pkt_buffer_pkg::DATA_WIDTH_DEFAULT,
	parameter int DEPTH      = pkt_buffer_pkg::FIFO_DEPTH_DEFAULT
) (
	input  logic                          wr_clk,
	input  logic                          rd_clk,
	input  logic                          rd_reset,	// Only reset, rd_clk domain

	// Input port, wr_clk domain
	input  logic                          in_req,
	output logic                          in_ack,
	input  logic [DATA_WIDTH-1:0]         in_data,
	input  logic                          in_last,
	output pkt_buffer_pkg::pkt_status_t   in_status,

	// Output port, rd_clk domain
	output logic                          out_req,
	input  logic                          out_ack,
	output logic [DATA_WIDTH-1:0]         out_data,
	output logic                          out_last
);

	localparam int ADDR_BITS = $clog2(DEPTH);

	//////////////////////////////////////////////////////////////////////
	// Internal buses

	logic                  wr_reset;	// From the core reset synchronizer
	logic                  wr_en;
	logic [DATA_WIDTH-1:0] wr_data;
	logic                  wr_commit;
	logic                  wr_rollback;
	logic [ADDR_BITS:0]    wr_size;
	logic                  rd_en;
	logic [ADDR_BITS-1:0]  rd_offset;
	logic [DATA_WIDTH-1:0] rd_data;
	logic                  rd_pop_packet;
	logic [ADDR_BITS:0]    rd_packet_size;
	logic [ADDR_BITS:0]    rd_size;

	packet_ingress #(.DATA_WIDTH(DATA_WIDTH), .DEPTH(DEPTH)) u_ingress (
		.wr_clk, .wr_reset,
		.in_req, .in_ack, .in_data, .in_last, .in_status,
		.wr_en, .wr_data, .wr_commit, .wr_rollback, .wr_size
	);

	packet_fifo_core #(.DATA_WIDTH(DATA_WIDTH), .DEPTH(DEPTH)) u_core (
		.wr_clk, .wr_reset, .wr_en, .wr_data, .wr_commit, .wr_rollback, .wr_size,
		.rd_clk, .rd_reset, .rd_en, .rd_offset, .rd_data,
		.rd_pop_packet, .rd_packet_size, .rd_size
	);

	packet_egress #(.DATA_WIDTH(DATA_WIDTH), .DEPTH(DEPTH)) u_egress (
		.rd_clk, .rd_reset,
		.rd_en, .rd_offset, .rd_data, .rd_size, .rd_pop_packet, .rd_packet_size,
		.out_req, .out_ack, .out_data, .out_last
	);

endmodule

// File: verification/packet_buffer_tb.sv
`timescale 1ns/1ps

module packet_buffer_tb;

	localparam int DATA_WIDTH    = pkt_buffer_pkg::DATA_WIDTH_DEFAULT;
	localparam int DEPTH         = pkt_buffer_pkg::FIFO_DEPTH_DEFAULT;
	localparam int SEED          = 92403;
	localparam int N_GOOD        = 20;
	localparam int N_BAD         = 12;	// Each followed by one good packet
	localparam int N_STALL       = 12;
	localparam int N_BACKP       = 20;
	localparam int N_WRAP        = 16;
	localparam int N_PACKETS     = N_GOOD + 2 * N_BAD + N_STALL + N_BACKP + N_WRAP;
	localparam int SETTLE_CYCLES = 40;	// Pop reaches wr_size well within this

	// Four wr_clk cycles per input word plus gaps, up to 18 rd_clk cycles per output word
	localparam int     WORD_NS    = 300;
	localparam longint TIMEOUT_NS = longint'(N_PACKETS) * (DEPTH + 4) * WORD_NS + 20000;

	logic                        wr_clk = 1'b0;
	logic                        rd_clk = 1'b0;
	logic                        rd_reset;
	logic                        in_req;
	logic                        in_ack;
	logic [DATA_WIDTH-1:0]       in_data;
	logic                        in_last;
	pkt_buffer_pkg::pkt_status_t in_status;
	logic                        out_req;
	logic                        out_ack;
	logic [DATA_WIDTH-1:0]       out_data;
	logic                        out_last;

	// Reference model, payload words of committed packets in order
	logic [DATA_WIDTH-1:0] exp_data [$];
	bit                    exp_last [$];
	int committed_words = 0;	// Header plus payload of every PKT_OK packet
	int freed_words     = 0;	// Same, once popped and settled
	int packets_out     = 0;
	int errors          = 0;
	int checks          = 0;
	int max_ack_delay   = 2;
	int max_gap         = 2;
	bit ack_enable      = 1'b1;

	always #7 wr_clk = ~wr_clk;
	always #5 rd_clk = ~rd_clk;

	packet_buffer_top #(.DATA_WIDTH(DATA_WIDTH), .DEPTH(DEPTH)) u_dut (
		.wr_clk, .rd_clk, .rd_reset,
		.in_req, .in_ack, .in_data, .in_last, .in_status,
		.out_req, .out_ack, .out_data, .out_last
	);

	//////////////////////////////////////////////////////////////////////
	// Helpers

	task automatic check_value(input string name, input logic [63:0] got,
			input logic [63:0] expected);
		checks++;
		if (got !== expected) begin
			errors++;
			$display("[ERROR] %0t ns %s: got %0h, expected %0h", $time, name, got, expected);
		end
	endtask

	// Outcome by the ingress rules, space check first
	function automatic pkt_buffer_pkg::pkt_status_t expected_status(input int len,
			input int n_payload, input int free);
		if (len + 1 > free)
			return pkt_buffer_pkg::PKT_NO_SPACE;
		if (len == 0)
			return pkt_buffer_pkg::PKT_ZERO_LENGTH;
		if (n_payload != len)
			return pkt_buffer_pkg::PKT_BAD_LENGTH;
		return pkt_buffer_pkg::PKT_OK;
	endfunction

	task automatic apply_reset();
		@(negedge rd_clk);
		rd_reset = 1'b1;
		repeat (3) @(negedge rd_clk);
		rd_reset = 1'b0;
		repeat (4) @(negedge wr_clk);	// Write side leaves reset through the synchronizer
	endtask

	// One four-phase word, status sampled while in_ack is high
	task automatic send_word(input logic [DATA_WIDTH-1:0] data, input logic last,
			output pkt_buffer_pkg::pkt_status_t status);
		in_data = data;
		in_last = last;
		in_req  = 1'b1;
		@(negedge wr_clk);
		while (!in_ack) @(negedge wr_clk);
		status = in_status;
		in_req = 1'b0;
		@(negedge wr_clk);
		while (in_ack) @(negedge wr_clk);	// Last phase
		repeat ($urandom_range(max_gap, 0)) @(negedge wr_clk);
	endtask

	task automatic send_packet(input int len, input int n_payload, input bit wait_room);
		int                          free;
		int                          i;
		pkt_buffer_pkg::pkt_status_t want;
		pkt_buffer_pkg::pkt_status_t got;
		logic [DATA_WIDTH-1:0]       word;
		// Hold off until the model knows the FIFO has room
		if (wait_room && len + 1 <= DEPTH)
			while (len + 1 > DEPTH - (committed_words - freed_words)) @(negedge wr_clk);
		free = DEPTH - (committed_words - freed_words);
		want = expected_status(len, n_payload, free);
		if (want == pkt_buffer_pkg::PKT_OK)
			committed_words += len + 1;
		send_word(DATA_WIDTH'(len), n_payload == 0, got);	// Header
		for (i = 1; i <= n_payload; i++) begin
			word = $urandom();
			if (want == pkt_buffer_pkg::PKT_OK) begin
				exp_data.push_back(word);	// Queued before commit can happen
				exp_last.push_back(i == n_payload);
			end
			send_word(word, i == n_payload, got);
		end
		check_value("in_status", 64'(got), 64'(want));
		repeat ($urandom_range(4 * max_gap, 0)) @(negedge wr_clk);	// Gap between packets
	endtask

	task automatic wait_drained();
		while (exp_data.size() != 0 || committed_words != freed_words) @(negedge wr_clk);
	endtask

	task automatic report_test(input string name, input int err_mark);
		$display("[%0t ns] %s: %0d errors", $time, name, errors - err_mark);
	endtask

	//////////////////////////////////////////////////////////////////////
	// Sink with random ack delay

	initial begin : receiver
		int delay;
		int words;
		bit got_last;
		out_ack = 1'b0;
		words   = 0;
		forever begin
			@(negedge rd_clk);
			if (out_req && ack_enable) begin
				delay = $urandom_range(max_ack_delay, 0);
				repeat (delay) @(negedge rd_clk);	// out_data must hold meanwhile
				got_last = out_last;
				if (exp_data.size() == 0) begin
					errors++;
					$display("Output word %0h at %0t ns while no packet was expected",
						out_data, $time);
				end else begin
					check_value("out_data", 64'(out_data), 64'(exp_data.pop_front()));
					check_value("out_last", 64'(out_last), 64'(exp_last.pop_front()));
				end
				out_ack = 1'b1;
				@(negedge rd_clk);
				while (out_req) @(negedge rd_clk);
				out_ack = 1'b0;
				words++;
				if (got_last) begin
					repeat (SETTLE_CYCLES) @(negedge rd_clk);	// Pop crosses to wr_clk
					freed_words += words + 1;	// Payload plus header
					words = 0;
					packets_out++;
				end
			end
		end
	end

	initial begin : watchdog
		#(TIMEOUT_NS);
		$display("Watchdog expired after %0d ns, a handshake never completed", TIMEOUT_NS);
		$display("Test failed");
		$finish;
	end

	//////////////////////////////////////////////////////////////////////
	// Test sequence

	initial begin : main_seq
		int i;
		int len;
		int n;
		int err_mark;
		int out_mark;
		void'($urandom(SEED));
		in_req    = 1'b0;
		in_data   = '0;
		in_last   = 1'b0;
		rd_reset  = 1'b1;

		// Reset state
		err_mark = errors;
		apply_reset();
		check_value("in_ack", 64'(in_ack), 64'(0));
		check_value("out_req", 64'(out_req), 64'(0));
		repeat (10) @(negedge rd_clk);
		check_value("out_req", 64'(out_req), 64'(0));
		report_test("reset state", err_mark);

		// Good packets with random gaps
		err_mark = errors;
		out_mark = packets_out;
		@(negedge wr_clk);	// Inputs change on wr_clk falling edges
		for (i = 0; i < N_GOOD; i++) begin
			len = $urandom_range(DEPTH - 1, 1);
			send_packet(len, len, 1'b1);
		end
		wait_drained();
		check_value("packets_out", 64'(packets_out - out_mark), 64'(N_GOOD));
		report_test("good packets", err_mark);

		// Bad packets, each chased by a good one
		err_mark = errors;
		out_mark = packets_out;
		for (i = 0; i < N_BAD; i++) begin
			if (i % 4 == 0) begin
				send_packet(0, 0, 1'b1);	// Zero length
			end else begin
				len = $urandom_range(DEPTH - 1, 1);
				n   = $urandom_range(1, 0) ? len + 1 : len - 1;	// One word too many or too few
				send_packet(len, n, 1'b1);
			end
			len = $urandom_range(DEPTH - 1, 1);
			send_packet(len, len, 1'b1);
		end
		wait_drained();
		check_value("packets_out", 64'(packets_out - out_mark), 64'(N_BAD));
		report_test("bad packets", err_mark);

		// Output stalled from a fresh reset, nothing popped
		err_mark = errors;
		ack_enable = 1'b0;
		apply_reset();
		for (i = 0; i < N_STALL; i++) begin
			len = $urandom_range(DEPTH + 4, 0);
			send_packet(len, len, 1'b0);	// Free space is DEPTH minus committed words
		end
		ack_enable = 1'b1;
		wait_drained();
		report_test("no space", err_mark);

		// Long random ack delays
		err_mark = errors;
		out_mark = packets_out;
		max_ack_delay = 12;
		for (i = 0; i < N_BACKP; i++) begin
			len = $urandom_range(DEPTH - 1, 1);
			send_packet(len, len, 1'b1);
		end
		wait_drained();
		max_ack_delay = 2;
		check_value("packets_out", 64'(packets_out - out_mark), 64'(N_BACKP));
		report_test("back-pressure", err_mark);

		// Long packets, pointers wrap several times
		err_mark = errors;
		out_mark = packets_out;
		for (i = 0; i < N_WRAP; i++) begin
			len = $urandom_range(DEPTH - 1, DEPTH / 4);
			send_packet(len, len, 1'b1);
		end
		wait_drained();
		check_value("packets_out", 64'(packets_out - out_mark), 64'(N_WRAP));
		report_test("wrap-around", err_mark);

		$display("Summary: %0d checks, %0d errors, %0d packets received",
			checks, errors, packets_out);
		if (errors == 0)
			$display("Test passed");
		else
			$display("Test failed");
		$finish;
	end

endmodule

// File: list.f
rtl/pkt_buffer_pkg.sv
rtl/dual_port_ram.sv
rtl/pointer_sync.sv
rtl/packet_fifo_core.sv
rtl/packet_ingress.sv
rtl/packet_egress.sv
rtl/packet_buffer_top.sv
verification/packet_buffer_tb.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing -Mdir obj_dir
TOP       = packet_buffer_tb
FILELIST  = list.f
LOG       = sim.log
BIN       = obj_dir/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

run: compile
	./$(BIN) | tee $(LOG)
	grep -q "Test passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
